/* src/rv_decode_pkg.sv */
package rv_decode_pkg;

    // word and register address widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // major opcodes kept by the decoder
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;

    // branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;
    localparam logic [2:0] F3_SRL_SRA = 3'b101; // shift right, logical or arithmetic

    // alu mode is {funct7[0], funct7[5], funct3}
    localparam int ALU_MODE_W = 5;
    localparam logic [ALU_MODE_W-1:0] ALU_ADD   = 5'b00000;
    localparam logic [ALU_MODE_W-1:0] ALU_COPY1 = 5'b01111; // pass operand 1 through

    localparam int MA_MODE_W = 2;
    localparam logic [MA_MODE_W-1:0] MA_NONE  = 2'd0;
    localparam logic [MA_MODE_W-1:0] MA_LOAD  = 2'd1;
    localparam logic [MA_MODE_W-1:0] MA_STORE = 2'd2;

    // store size comes straight from funct3
    localparam int MA_SIZE_W = 3;
    localparam logic [MA_SIZE_W-1:0] MA_SIZE_WORD = 3'b010;

    localparam int WB_SRC_W = 2;
    localparam logic [WB_SRC_W-1:0] WB_SRC_NONE = 2'd0;
    localparam logic [WB_SRC_W-1:0] WB_SRC_ALU  = 2'd1;
    localparam logic [WB_SRC_W-1:0] WB_SRC_MEM  = 2'd2;
    localparam logic [WB_SRC_W-1:0] WB_SRC_PC4  = 2'd3;

    localparam int OP1_SEL_W = 2;
    localparam logic [OP1_SEL_W-1:0] OP1_ZERO = 2'd0;
    localparam logic [OP1_SEL_W-1:0] OP1_RS1  = 2'd1;
    localparam logic [OP1_SEL_W-1:0] OP1_IMMU = 2'd2;

    localparam int OP2_SEL_W = 3;
    localparam logic [OP2_SEL_W-1:0] OP2_ZERO = 3'd0;
    localparam logic [OP2_SEL_W-1:0] OP2_RS2  = 3'd1;
    localparam logic [OP2_SEL_W-1:0] OP2_IMMI = 3'd2;
    localparam logic [OP2_SEL_W-1:0] OP2_IMMS = 3'd3;
    localparam logic [OP2_SEL_W-1:0] OP2_PC   = 3'd4;

    localparam int PC_MODE_W = 2;
    localparam logic [PC_MODE_W-1:0] PC_NEXT     = 2'd0;
    localparam logic [PC_MODE_W-1:0] PC_JUMP_REL = 2'd1;
    localparam logic [PC_MODE_W-1:0] PC_JUMP_ABS = 2'd2;
    localparam logic [PC_MODE_W-1:0] PC_BRANCH   = 2'd3;

    // bubble values, addi x0, x0, 0
    localparam logic [XLEN-1:0] NOP_IR = 32'h0000_0013;
    localparam logic [XLEN-1:0] NOP_PC = 32'h0000_0000;

    // one instruction word, six encodings
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } instr_u;

endpackage

/* src/rv_instr_decoder.sv */
`timescale 1ns/1ps

module rv_instr_decoder import rv_decode_pkg::*; (
    input  instr_u                ir_i,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output logic [2:0]            funct3_o,
    output logic [XLEN-1:0]       imm_i_o,
    output logic [XLEN-1:0]       imm_s_o,
    output logic [XLEN-1:0]       imm_b_o,
    output logic [XLEN-1:0]       imm_u_o,
    output logic [XLEN-1:0]       imm_j_o,
    output logic [OP1_SEL_W-1:0]  op1_sel_o,
    output logic [OP2_SEL_W-1:0]  op2_sel_o,
    output logic [PC_MODE_W-1:0]  pc_mode_o,
    output logic [ALU_MODE_W-1:0] alu_mode_o,
    output logic [MA_MODE_W-1:0]  ma_mode_o,
    output logic [MA_SIZE_W-1:0]  ma_size_o,
    output logic [WB_SRC_W-1:0]   wb_src_o,
    output logic                  rs1_used_o,
    output logic                  rs2_used_o,
    output logic                  halt_o
);

    logic [6:0]            opcode;
    logic [6:0]            funct7;
    logic [ALU_MODE_W-1:0] mode7; // funct7 bits plus funct3
    logic [ALU_MODE_W-1:0] mode3; // funct3 only
    logic                  rs1_used;
    logic                  rs2_used;

    assign opcode   = ir_i.r_fmt.opcode;
    assign funct7   = ir_i.r_fmt.funct7;
    assign funct3_o = ir_i.r_fmt.funct3;
    assign rs1_o    = ir_i.r_fmt.rs1;
    assign rs2_o    = ir_i.r_fmt.rs2;
    assign rd_o     = ir_i.r_fmt.rd;

    assign mode7 = {funct7[0], funct7[5], funct3_o};
    assign mode3 = {2'b00, funct3_o};

    // immediates, all sign extended from bit 31 except U
    assign imm_i_o = {{20{ir_i.i_fmt.imm_11_0[11]}}, ir_i.i_fmt.imm_11_0};
    assign imm_s_o = {{20{ir_i.s_fmt.imm_11_5[6]}}, ir_i.s_fmt.imm_11_5, ir_i.s_fmt.imm_4_0};
    assign imm_b_o = {{19{ir_i.b_fmt.imm_12}}, ir_i.b_fmt.imm_12, ir_i.b_fmt.imm_11,
                      ir_i.b_fmt.imm_10_5, ir_i.b_fmt.imm_4_1, 1'b0};
    assign imm_u_o = {ir_i.u_fmt.imm_31_12, 12'b0};
    assign imm_j_o = {{11{ir_i.j_fmt.imm_20}}, ir_i.j_fmt.imm_20, ir_i.j_fmt.imm_19_12,
                      ir_i.j_fmt.imm_11, ir_i.j_fmt.imm_10_1, 1'b0};

    always_comb begin
        op1_sel_o  = OP1_ZERO;
        op2_sel_o  = OP2_ZERO;
        pc_mode_o  = PC_NEXT;
        alu_mode_o = ALU_ADD;
        ma_mode_o  = MA_NONE;
        ma_size_o  = MA_SIZE_WORD;
        wb_src_o   = WB_SRC_NONE;
        rs1_used   = 1'b0;
        rs2_used   = 1'b0;
        halt_o     = 1'b0;
        case (opcode)
            OPC_OP: begin
                op1_sel_o  = OP1_RS1;
                op2_sel_o  = OP2_RS2;
                alu_mode_o = mode7;
                wb_src_o   = WB_SRC_ALU;
                rs1_used   = 1'b1;
                rs2_used   = 1'b1;
            end
            OPC_OP_IMM: begin
                op1_sel_o  = OP1_RS1;
                op2_sel_o  = OP2_IMMI;
                alu_mode_o = (funct3_o == F3_SRL_SRA) ? mode7 : mode3; // srai needs funct7[5]
                wb_src_o   = WB_SRC_ALU;
                rs1_used   = 1'b1;
            end
            OPC_LUI: begin
                op1_sel_o  = OP1_IMMU;
                alu_mode_o = ALU_COPY1;
                wb_src_o   = WB_SRC_ALU;
            end
            OPC_AUIPC: begin
                op1_sel_o = OP1_IMMU;
                op2_sel_o = OP2_PC;
                wb_src_o  = WB_SRC_ALU;
            end
            OPC_JAL: begin
                pc_mode_o = PC_JUMP_REL;
                wb_src_o  = WB_SRC_PC4;
            end
            OPC_JALR: begin
                pc_mode_o = PC_JUMP_ABS;
                wb_src_o  = WB_SRC_PC4;
                rs1_used  = 1'b1;
            end
            OPC_BRANCH: begin
                pc_mode_o = PC_BRANCH;
                rs1_used  = 1'b1;
                rs2_used  = 1'b1;
                halt_o    = (funct3_o[2:1] == 2'b01); // no branch at 010, 011
            end
            OPC_LOAD: begin
                op1_sel_o = OP1_RS1;
                op2_sel_o = OP2_IMMI;
                ma_mode_o = MA_LOAD;
                wb_src_o  = WB_SRC_MEM;
                rs1_used  = 1'b1;
            end
            OPC_STORE: begin
                op1_sel_o = OP1_RS1;
                op2_sel_o = OP2_IMMS;
                ma_mode_o = MA_STORE;
                ma_size_o = funct3_o;
                rs1_used  = 1'b1;
                rs2_used  = 1'b1;
            end
            OPC_MISC_MEM: ; // fence acts as a nop here
            default: halt_o = 1'b1; // SYSTEM and anything unknown
        endcase
    end

    // x0 never creates a dependency
    assign rs1_used_o = rs1_used && (rs1_o != '0);
    assign rs2_used_o = rs2_used && (rs2_o != '0);

endmodule

/* src/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile import rv_decode_pkg::*; (
    input  logic                  clk_i,
    input  logic [REG_ADDR_W-1:0] rd1_addr_i,
    output logic [XLEN-1:0]       rd1_data_o,
    input  logic [REG_ADDR_W-1:0] rd2_addr_i,
    output logic [XLEN-1:0]       rd2_data_o,
    input  logic [REG_ADDR_W-1:0] wr_addr_i,
    input  logic [XLEN-1:0]       wr_data_i,
    input  logic                  wr_en_i
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk_i) begin
        if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // x0 reads as zero whatever the array holds
    assign rd1_data_o = (rd1_addr_i == '0) ? '0 : regs[rd1_addr_i];
    assign rd2_data_o = (rd2_addr_i == '0) ? '0 : regs[rd2_addr_i];

endmodule

/* src/rv_operand_bypass.sv */
`timescale 1ns/1ps

module rv_operand_bypass import rv_decode_pkg::*; (
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [REG_ADDR_W-1:0] rs2_i,
    input  logic                  rs1_used_i,
    input  logic                  rs2_used_i,
    input  logic [XLEN-1:0]       rf1_data_i,
    input  logic [XLEN-1:0]       rf2_data_i,
    input  logic [REG_ADDR_W-1:0] ex_wb_addr_i,
    input  logic [XLEN-1:0]       ex_wb_data_i,
    input  logic                  ex_wb_valid_i,
    input  logic                  ex_wb_ready_i,
    input  logic [REG_ADDR_W-1:0] ma_wb_addr_i,
    input  logic [XLEN-1:0]       ma_wb_data_i,
    input  logic                  ma_wb_valid_i,
    input  logic                  ma_wb_ready_i,
    input  logic [REG_ADDR_W-1:0] wb_addr_i,
    input  logic [XLEN-1:0]       wb_data_i,
    input  logic                  wb_valid_i,
    output logic [XLEN-1:0]       rs1_value_o,
    output logic [XLEN-1:0]       rs2_value_o,
    output logic                  hazard_o
);

    // youngest producer wins, then the register file
    function automatic logic [XLEN-1:0] forward(input logic [REG_ADDR_W-1:0] addr,
                                                input logic [XLEN-1:0] rf_data);
        logic [XLEN-1:0] value;
        value = rf_data;
        if (addr != '0) begin
            if (ex_wb_valid_i && (ex_wb_addr_i == addr)) begin
                value = ex_wb_data_i;
            end else if (ma_wb_valid_i && (ma_wb_addr_i == addr)) begin
                value = ma_wb_data_i;
            end else if (wb_valid_i && (wb_addr_i == addr)) begin
                value = wb_data_i;
            end
        end
        return value;
    endfunction

    // result not computed yet in ex or ma
    function automatic logic pending(input logic [REG_ADDR_W-1:0] addr, input logic used);
        logic ex_wait;
        logic ma_wait;
        ex_wait = ex_wb_valid_i && !ex_wb_ready_i && (ex_wb_addr_i == addr);
        ma_wait = ma_wb_valid_i && !ma_wb_ready_i && (ma_wb_addr_i == addr);
        return used && (ex_wait || ma_wait);
    endfunction

    always_comb begin
        rs1_value_o = forward(rs1_i, rf1_data_i);
        rs2_value_o = forward(rs2_i, rf2_data_i);
        hazard_o    = pending(rs1_i, rs1_used_i) || pending(rs2_i, rs2_used_i);
    end

endmodule

/* src/rv_branch_unit.sv */
`timescale 1ns/1ps

module rv_branch_unit import rv_decode_pkg::*; (
    input  logic [XLEN-1:0]      pc_i,
    input  logic [PC_MODE_W-1:0] pc_mode_i,
    input  logic [2:0]           funct3_i,
    input  logic [XLEN-1:0]      rs1_value_i,
    input  logic [XLEN-1:0]      rs2_value_i,
    input  logic [XLEN-1:0]      imm_i_i,
    input  logic [XLEN-1:0]      imm_b_i,
    input  logic [XLEN-1:0]      imm_j_i,
    output logic                 jmp_valid_o,
    output logic [XLEN-1:0]      jmp_addr_o
);

    logic cond; // compare result before the funct3[0] inversion

    always_comb begin
        case (funct3_i[2:1])
            2'b00:   cond = (rs1_value_i == rs2_value_i);
            2'b10:   cond = ($signed(rs1_value_i) < $signed(rs2_value_i));
            2'b11:   cond = (rs1_value_i < rs2_value_i);
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        case (pc_mode_i)
            PC_JUMP_REL: begin
                jmp_valid_o = 1'b1;
                jmp_addr_o  = pc_i + imm_j_i;
            end
            PC_JUMP_ABS: begin
                jmp_valid_o = 1'b1;
                jmp_addr_o  = rs1_value_i + imm_i_i; // jalr
            end
            PC_BRANCH: begin
                jmp_valid_o = cond ^ funct3_i[0];
                jmp_addr_o  = pc_i + imm_b_i;
            end
            default: begin
                jmp_valid_o = 1'b0;
                jmp_addr_o  = '0;
            end
        endcase
    end

endmodule

/* src/rv_decode_stage.sv */
`timescale 1ns/1ps

module rv_decode_stage import rv_decode_pkg::*; (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [XLEN-1:0]       ir_i,
    input  logic [REG_ADDR_W-1:0] ex_wb_addr_i,
    input  logic [XLEN-1:0]       ex_wb_data_i,
    input  logic                  ex_wb_valid_i,
    input  logic                  ex_wb_ready_i,
    input  logic [REG_ADDR_W-1:0] ma_wb_addr_i,
    input  logic [XLEN-1:0]       ma_wb_data_i,
    input  logic                  ma_wb_valid_i,
    input  logic                  ma_wb_ready_i,
    input  logic [REG_ADDR_W-1:0] wb_addr_i,
    input  logic [XLEN-1:0]       wb_data_i,
    input  logic                  wb_valid_i,
    output logic                  ready_o,
    output logic                  jmp_valid_o,
    output logic [XLEN-1:0]       jmp_addr_o,
    output logic [XLEN-1:0]       pc_o,
    output logic [XLEN-1:0]       ir_o,
    output logic [XLEN-1:0]       alu_op1_o,
    output logic [XLEN-1:0]       alu_op2_o,
    output logic [ALU_MODE_W-1:0] alu_mode_o,
    output logic [MA_MODE_W-1:0]  ma_mode_o,
    output logic [MA_SIZE_W-1:0]  ma_size_o,
    output logic [XLEN-1:0]       ma_data_o,
    output logic [WB_SRC_W-1:0]   wb_src_o,
    output logic [XLEN-1:0]       wb_data_o,
    output logic                  wb_valid_o,
    output logic                  halt_o
);

    logic [REG_ADDR_W-1:0] rs1, rs2, rd;
    logic [2:0]            funct3;
    logic [XLEN-1:0]       imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [OP1_SEL_W-1:0]  op1_sel;
    logic [OP2_SEL_W-1:0]  op2_sel;
    logic [PC_MODE_W-1:0]  pc_mode;
    logic [ALU_MODE_W-1:0] alu_mode;
    logic [MA_MODE_W-1:0]  ma_mode;
    logic [MA_SIZE_W-1:0]  ma_size;
    logic [WB_SRC_W-1:0]   wb_src;
    logic                  rs1_used, rs2_used, halt;
    logic [XLEN-1:0]       rf1_data, rf2_data;
    logic [XLEN-1:0]       rs1_value, rs2_value;
    logic                  hazard;
    logic                  br_valid;
    logic [XLEN-1:0]       br_addr;
    logic [XLEN-1:0]       alu_op1, alu_op2;
    logic                  wb_valid;

    rv_instr_decoder decoder_i (
        .ir_i(ir_i), .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .funct3_o(funct3),
        .imm_i_o(imm_i), .imm_s_o(imm_s), .imm_b_o(imm_b), .imm_u_o(imm_u), .imm_j_o(imm_j),
        .op1_sel_o(op1_sel), .op2_sel_o(op2_sel), .pc_mode_o(pc_mode),
        .alu_mode_o(alu_mode), .ma_mode_o(ma_mode), .ma_size_o(ma_size), .wb_src_o(wb_src),
        .rs1_used_o(rs1_used), .rs2_used_o(rs2_used), .halt_o(halt)
    );

    // write port comes straight from the wb stage
    rv_regfile regfile_i (
        .clk_i(clk_i),
        .rd1_addr_i(rs1), .rd1_data_o(rf1_data),
        .rd2_addr_i(rs2), .rd2_data_o(rf2_data),
        .wr_addr_i(wb_addr_i), .wr_data_i(wb_data_i), .wr_en_i(wb_valid_i)
    );

    rv_operand_bypass bypass_i (
        .rs1_i(rs1), .rs2_i(rs2), .rs1_used_i(rs1_used), .rs2_used_i(rs2_used),
        .rf1_data_i(rf1_data), .rf2_data_i(rf2_data),
        .ex_wb_addr_i(ex_wb_addr_i), .ex_wb_data_i(ex_wb_data_i),
        .ex_wb_valid_i(ex_wb_valid_i), .ex_wb_ready_i(ex_wb_ready_i),
        .ma_wb_addr_i(ma_wb_addr_i), .ma_wb_data_i(ma_wb_data_i),
        .ma_wb_valid_i(ma_wb_valid_i), .ma_wb_ready_i(ma_wb_ready_i),
        .wb_addr_i(wb_addr_i), .wb_data_i(wb_data_i), .wb_valid_i(wb_valid_i),
        .rs1_value_o(rs1_value), .rs2_value_o(rs2_value), .hazard_o(hazard)
    );

    rv_branch_unit branch_i (
        .pc_i(pc_i), .pc_mode_i(pc_mode), .funct3_i(funct3),
        .rs1_value_i(rs1_value), .rs2_value_i(rs2_value),
        .imm_i_i(imm_i), .imm_b_i(imm_b), .imm_j_i(imm_j),
        .jmp_valid_o(br_valid), .jmp_addr_o(br_addr)
    );

    always_comb begin
        case (op1_sel)
            OP1_RS1:  alu_op1 = rs1_value;
            OP1_IMMU: alu_op1 = imm_u;
            default:  alu_op1 = '0;
        endcase
        case (op2_sel)
            OP2_RS2:  alu_op2 = rs2_value;
            OP2_IMMI: alu_op2 = imm_i;
            OP2_IMMS: alu_op2 = imm_s;
            OP2_PC:   alu_op2 = pc_i;
            default:  alu_op2 = '0;
        endcase
    end

    assign wb_valid = (wb_src != WB_SRC_NONE) && (rd != '0);

    // same-cycle outputs toward fetch, held idle in reset
    assign jmp_valid_o = !reset_i && br_valid;
    assign jmp_addr_o  = reset_i ? '0 : br_addr;
    assign ready_o     = reset_i || !hazard;

    always_ff @(posedge clk_i) begin
        if (reset_i || hazard) begin // bubble
            pc_o       <= NOP_PC;
            ir_o       <= NOP_IR;
            alu_op1_o  <= '0;
            alu_op2_o  <= '0;
            alu_mode_o <= ALU_ADD;
            ma_mode_o  <= MA_NONE;
            ma_size_o  <= MA_SIZE_WORD;
            ma_data_o  <= '0;
            wb_src_o   <= WB_SRC_NONE;
            wb_data_o  <= '0;
            wb_valid_o <= 1'b0;
            halt_o     <= 1'b0;
        end else begin
            pc_o       <= pc_i;
            ir_o       <= ir_i;
            alu_op1_o  <= alu_op1;
            alu_op2_o  <= alu_op2;
            alu_mode_o <= alu_mode;
            ma_mode_o  <= ma_mode;
            ma_size_o  <= ma_size;
            ma_data_o  <= rs2_value; // store data
            wb_src_o   <= wb_src;
            wb_data_o  <= pc_i + 32'd4; // link address for jal and jalr
            wb_valid_o <= wb_valid;
            halt_o     <= halt;
        end
    end

endmodule

/* verification/decode_stage_checker.sv */
`timescale 1ns/1ps

module decode_stage_checker import rv_decode_pkg::*; (
    input logic                 clk_i,
    input logic                 reset_i,
    input logic                 ready_i,
    input logic                 jmp_valid_i,
    input logic                 wb_valid_i,
    input logic                 halt_i,
    input logic [MA_MODE_W-1:0] ma_mode_i
);

    // fetch sees an idle stage during reset
    reset_idle: assert property (@(posedge clk_i) reset_i |-> (!jmp_valid_i && ready_i))
        else $error("jump or stall seen during reset");

    // a stall cycle always leaves a bubble behind
    stall_no_wb: assert property (@(posedge clk_i) disable iff (reset_i)
        !ready_i |=> !wb_valid_i)
        else $error("write-back valid after a stall");

    stall_no_ma: assert property (@(posedge clk_i) disable iff (reset_i)
        !ready_i |=> (ma_mode_i == MA_NONE))
        else $error("memory access after a stall");

    halt_after_reset: assert property (@(posedge clk_i) $fell(reset_i) |=> !halt_i)
        else $error("halt set right after reset");

endmodule

bind rv_decode_stage decode_stage_checker checker_i (
    .clk_i(clk_i), .reset_i(reset_i), .ready_i(ready_o), .jmp_valid_i(jmp_valid_o),
    .wb_valid_i(wb_valid_o), .halt_i(halt_o), .ma_mode_i(ma_mode_o)
);

/* verification/tb_decode_stage.sv */
`timescale 1ns/1ps

module tb_decode_stage import rv_decode_pkg::*; ();

    logic                  clk_i;
    logic                  reset_i;
    logic [XLEN-1:0]       pc_i;
    logic [XLEN-1:0]       ir_i;
    logic [REG_ADDR_W-1:0] ex_wb_addr_i;
    logic [XLEN-1:0]       ex_wb_data_i;
    logic                  ex_wb_valid_i;
    logic                  ex_wb_ready_i;
    logic [REG_ADDR_W-1:0] ma_wb_addr_i;
    logic [XLEN-1:0]       ma_wb_data_i;
    logic                  ma_wb_valid_i;
    logic                  ma_wb_ready_i;
    logic [REG_ADDR_W-1:0] wb_addr_i;
    logic [XLEN-1:0]       wb_data_i;
    logic                  wb_valid_i;
    logic                  ready_o;
    logic                  jmp_valid_o;
    logic [XLEN-1:0]       jmp_addr_o;
    logic [XLEN-1:0]       pc_o;
    logic [XLEN-1:0]       ir_o;
    logic [XLEN-1:0]       alu_op1_o;
    logic [XLEN-1:0]       alu_op2_o;
    logic [ALU_MODE_W-1:0] alu_mode_o;
    logic [MA_MODE_W-1:0]  ma_mode_o;
    logic [MA_SIZE_W-1:0]  ma_size_o;
    logic [XLEN-1:0]       ma_data_o;
    logic [WB_SRC_W-1:0]   wb_src_o;
    logic [XLEN-1:0]       wb_data_o;
    logic                  wb_valid_o;
    logic                  halt_o;

    logic [31:0] stim [13];     // pc, ir, ex x4, ma x4, wb x3
    logic [31:0] exp_comb [3];  // ready, jmp_valid, jmp_addr
    logic [31:0] exp_reg [12];  // pipeline outputs one edge later
    logic [31:0] prev_reg [12];
    string       name;
    string       prev_name;

    rv_decode_stage dut_i (.*);

    always #20 clk_i = ~clk_i;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %0s %0s expected %h actual %h", test, field, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic apply_stimulus();
        @(posedge clk_i);
        pc_i          <= stim[0];
        ir_i          <= stim[1];
        ex_wb_addr_i  <= stim[2][4:0];
        ex_wb_data_i  <= stim[3];
        ex_wb_valid_i <= stim[4][0];
        ex_wb_ready_i <= stim[5][0];
        ma_wb_addr_i  <= stim[6][4:0];
        ma_wb_data_i  <= stim[7];
        ma_wb_valid_i <= stim[8][0];
        ma_wb_ready_i <= stim[9][0];
        wb_addr_i     <= stim[10][4:0];
        wb_data_i     <= stim[11];
        wb_valid_i    <= stim[12][0];
    endtask

    task automatic check_comb();
        check_value(name, "ready_o", exp_comb[0], 32'(ready_o));
        check_value(name, "jmp_valid_o", exp_comb[1], 32'(jmp_valid_o));
        check_value(name, "jmp_addr_o", exp_comb[2], jmp_addr_o);
    endtask

    task automatic check_registered();
        check_value(prev_name, "pc_o", prev_reg[0], pc_o);
        check_value(prev_name, "ir_o", prev_reg[1], ir_o);
        check_value(prev_name, "alu_op1_o", prev_reg[2], alu_op1_o);
        check_value(prev_name, "alu_op2_o", prev_reg[3], alu_op2_o);
        check_value(prev_name, "alu_mode_o", prev_reg[4], 32'(alu_mode_o));
        check_value(prev_name, "ma_mode_o", prev_reg[5], 32'(ma_mode_o));
        check_value(prev_name, "ma_size_o", prev_reg[6], 32'(ma_size_o));
        check_value(prev_name, "ma_data_o", prev_reg[7], ma_data_o);
        check_value(prev_name, "wb_src_o", prev_reg[8], 32'(wb_src_o));
        check_value(prev_name, "wb_data_o", prev_reg[9], wb_data_o);
        check_value(prev_name, "wb_valid_o", prev_reg[10], 32'(wb_valid_o));
        check_value(prev_name, "halt_o", prev_reg[11], 32'(halt_o));
    endtask

    initial begin
        int    fd;
        int    n;
        int    cycles;
        int    lines;
        int    cases_run;
        string line;
        clk_i         = 1'b0;
        reset_i       = 1'b1;
        pc_i          = '0;
        ir_i          = NOP_IR; // keeps halt low right after reset
        ex_wb_addr_i  = '0;
        ex_wb_data_i  = '0;
        ex_wb_valid_i = 1'b0;
        ex_wb_ready_i = 1'b1;
        ma_wb_addr_i  = '0;
        ma_wb_data_i  = '0;
        ma_wb_valid_i = 1'b0;
        ma_wb_ready_i = 1'b1;
        wb_addr_i     = '0;
        wb_data_i     = '0;
        wb_valid_i    = 1'b0;
        cycles        = 0;
        lines         = 0;
        cases_run     = 0;

        repeat (5) @(posedge clk_i);
        reset_i <= 1'b0;
        while (reset_i) begin
            @(posedge clk_i);
            cycles++;
            if (cycles > 20) stop_with_error("reset was never released");
        end

        fd = $fopen("verification/decode_cases.txt", "r");
        if (fd == 0) stop_with_error("cannot open the case file");
        while (!$feof(fd)) begin
            lines++;
            if (lines > 500) stop_with_error("case file did not end");
            n = $fscanf(fd, "%s", name);
            if (n != 1) continue; // only white space left
            if (name.getc(0) == "#") begin
                n = $fgets(line, fd); // rest of a comment line
                continue;
            end
            n = 0;
            for (int i = 0; i < 13; i++) begin
                n += $fscanf(fd, "%h", stim[i]);
            end
            for (int i = 0; i < 3; i++) begin
                n += $fscanf(fd, "%h", exp_comb[i]);
            end
            for (int i = 0; i < 12; i++) begin
                n += $fscanf(fd, "%h", exp_reg[i]);
            end
            if (n != 28) stop_with_error("malformed line in the case file");
            apply_stimulus();
            @(negedge clk_i);
            check_comb();
            if (cases_run > 0) check_registered(); // previous line lands now
            prev_name = name;
            prev_reg  = exp_reg;
            cases_run++;
        end
        $fclose(fd);

        if (cases_run == 0) begin
            stop_with_error("no cases were read");
        end else begin
            @(posedge clk_i);
            @(negedge clk_i);
            check_registered();
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

/* verification/decode_cases.txt */
# name pc ir | ex addr data valid ready | ma addr data valid ready | wb addr data valid
# exp ready jv ja | exp pc ir op1 op2 alu_mode ma_mode ma_size ma_data wb_src wb_data wb_valid halt
pre_x1 0 13 0 0 0 1 0 0 0 1 1 10 1 1 0 0 0 13 0 0 0 0 2 0 1 4 0 0
pre_x2 0 13 0 0 0 1 0 0 0 1 2 fffffff0 1 1 0 0 0 13 0 0 0 0 2 0 1 4 0 0
pre_x3 0 13 0 0 0 1 0 0 0 1 3 7 1 1 0 0 0 13 0 0 0 0 2 0 1 4 0 0
pre_x5 0 13 0 0 0 1 0 0 0 1 5 1000 1 1 0 0 0 13 0 0 0 0 2 0 1 4 0 0
addi_x4 10 00308213 0 0 0 1 0 0 0 1 0 0 0 1 0 0 10 00308213 10 3 0 0 2 7 1 14 1 0
addi_x0 14 00108013 0 0 0 1 0 0 0 1 0 0 0 1 0 0 14 00108013 10 1 0 0 2 10 1 18 0 0
srai 18 40215313 0 0 0 1 0 0 0 1 0 0 0 1 0 0 18 40215313 fffffff0 402 d 0 2 fffffff0 1 1c 1 0
add 1c 003083b3 0 0 0 1 0 0 0 1 0 0 0 1 0 0 1c 003083b3 10 7 0 0 2 7 1 20 1 0
sub 20 40308433 0 0 0 1 0 0 0 1 0 0 0 1 0 0 20 40308433 10 7 8 0 2 7 1 24 1 0
lui 24 123454b7 0 0 0 1 0 0 0 1 0 0 0 1 0 0 24 123454b7 12345000 0 f 0 2 7 1 28 1 0
auipc 100 00001517 0 0 0 1 0 0 0 1 0 0 0 1 0 0 100 00001517 1000 100 0 0 2 0 1 104 1 0
lw 104 0032a583 0 0 0 1 0 0 0 1 0 0 0 1 0 0 104 0032a583 1000 3 0 1 2 7 2 108 1 0
sw 108 0032a223 0 0 0 1 0 0 0 1 0 0 0 1 0 0 108 0032a223 1000 4 0 2 2 7 0 10c 0 0
sb 10c fe228fa3 0 0 0 1 0 0 0 1 0 0 0 1 0 0 10c fe228fa3 1000 ffffffff 0 2 0 fffffff0 0 110 0 0
jal 200 020000ef 0 0 0 1 0 0 0 1 0 0 0 1 1 220 200 020000ef 0 0 0 0 2 0 3 204 1 0
jalr 300 022280e7 0 0 0 1 0 0 0 1 0 0 0 1 1 1022 300 022280e7 0 0 0 0 2 fffffff0 3 304 1 0
beq_t 400 00108463 0 0 0 1 0 0 0 1 0 0 0 1 1 408 400 00108463 0 0 0 0 2 10 0 404 0 0
beq_n 400 00308463 0 0 0 1 0 0 0 1 0 0 0 1 0 408 400 00308463 0 0 0 0 2 7 0 404 0 0
bne_t 400 00309463 0 0 0 1 0 0 0 1 0 0 0 1 1 408 400 00309463 0 0 0 0 2 7 0 404 0 0
bne_n 400 00109463 0 0 0 1 0 0 0 1 0 0 0 1 0 408 400 00109463 0 0 0 0 2 10 0 404 0 0
blt_t 400 00114463 0 0 0 1 0 0 0 1 0 0 0 1 1 408 400 00114463 0 0 0 0 2 10 0 404 0 0
blt_n 400 0020c463 0 0 0 1 0 0 0 1 0 0 0 1 0 408 400 0020c463 0 0 0 0 2 fffffff0 0 404 0 0
bge_t 400 0020d463 0 0 0 1 0 0 0 1 0 0 0 1 1 408 400 0020d463 0 0 0 0 2 fffffff0 0 404 0 0
bge_n 400 00115463 0 0 0 1 0 0 0 1 0 0 0 1 0 408 400 00115463 0 0 0 0 2 10 0 404 0 0
bltu_t 400 0020e463 0 0 0 1 0 0 0 1 0 0 0 1 1 408 400 0020e463 0 0 0 0 2 fffffff0 0 404 0 0
bltu_n 400 00116463 0 0 0 1 0 0 0 1 0 0 0 1 0 408 400 00116463 0 0 0 0 2 10 0 404 0 0
bgeu_t 400 00117463 0 0 0 1 0 0 0 1 0 0 0 1 1 408 400 00117463 0 0 0 0 2 10 0 404 0 0
bgeu_n 400 0020f463 0 0 0 1 0 0 0 1 0 0 0 1 0 408 400 0020f463 0 0 0 0 2 fffffff0 0 404 0 0
fwd_ex 500 00168633 d aaaa 1 1 d bbbb 1 1 d cccc 1 1 0 0 500 00168633 aaaa 10 0 0 2 10 1 504 1 0
fwd_ma 504 00168633 0 0 0 1 d bbbb 1 1 d dddd 1 1 0 0 504 00168633 bbbb 10 0 0 2 10 1 508 1 0
fwd_wb 508 00168633 0 0 0 1 0 0 0 1 d eeee 1 1 0 0 508 00168633 eeee 10 0 0 2 10 1 50c 1 0
fwd_rf 50c 00168633 0 0 0 1 0 0 0 1 0 0 0 1 0 0 50c 00168633 eeee 10 0 0 2 10 1 510 1 0
fwd_x0 510 00100633 0 5555 1 0 0 6666 1 1 0 7777 1 1 0 0 510 00100633 0 10 0 0 2 10 1 514 1 0
haz_ex 600 00168633 d 1111 1 0 0 0 0 1 0 0 0 0 0 0 0 13 0 0 0 0 2 0 0 0 0 0
rel_ex 600 00168633 d 2222 1 1 0 0 0 1 0 0 0 1 0 0 600 00168633 2222 10 0 0 2 10 1 604 1 0
haz_ma 604 00168633 0 0 0 1 1 9999 1 0 0 0 0 0 0 0 0 13 0 0 0 0 2 0 0 0 0 0
rel_ma 604 00168633 0 0 0 1 1 9999 1 1 0 0 0 1 0 0 604 00168633 eeee 9999 0 0 2 9999 1 608 1 0
bad_op 700 0000007f 0 0 0 1 0 0 0 1 0 0 0 1 0 0 700 0000007f 0 0 0 0 2 0 0 704 0 1
ecall 704 00000073 0 0 0 1 0 0 0 1 0 0 0 1 0 0 704 00000073 0 0 0 0 2 0 0 708 0 1

/* flist.f */
src/rv_decode_pkg.sv
src/rv_instr_decoder.sv
src/rv_regfile.sv
src/rv_operand_bypass.sv
src/rv_branch_unit.sv
src/rv_decode_stage.sv
verification/decode_stage_checker.sv
verification/tb_decode_stage.sv

/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module tb_decode_stage -f flist.f -Mdir obj_dir

run: compile
	./obj_dir/Vtb_decode_stage

clean:
	rm -rf obj_dir
